//--- Makefile
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
TOP       ?= muldiv_tb
FILELIST  ?= muldiv.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard source/*.sv source/*.svh bench/*.sv bench/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/muldiv_model.svh
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// RV32M funct3 codes
localparam logic [2:0] F3_MUL    = 3'b000;
localparam logic [2:0] F3_MULH   = 3'b001;
localparam logic [2:0] F3_MULHSU = 3'b010;
localparam logic [2:0] F3_MULHU  = 3'b011;
localparam logic [2:0] F3_DIV    = 3'b100;
localparam logic [2:0] F3_DIVU   = 3'b101;
localparam logic [2:0] F3_REM    = 3'b110;
localparam logic [2:0] F3_REMU   = 3'b111;

// ==================================================
// random numbers
// ==================================================

function automatic logic [31:0] lcg_step(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// ==================================================
// reference results
// ==================================================

function automatic logic [`MULDIV_XLEN-1:0] model_mul(input logic [2:0] f3,
    input logic [`MULDIV_XLEN-1:0] a, input logic [`MULDIV_XLEN-1:0] b);
  logic signed [2*`MULDIV_XLEN+1:0] wa;
  logic signed [2*`MULDIV_XLEN+1:0] wb;
  logic signed [2*`MULDIV_XLEN+1:0] full;
  // a signed for MULH and MULHSU
  if (f3 == F3_MULH || f3 == F3_MULHSU) begin
    wa = {{(`MULDIV_XLEN+2){a[`MULDIV_XLEN-1]}}, a};
  end else begin
    wa = {{(`MULDIV_XLEN+2){1'b0}}, a};
  end
  if (f3 == F3_MULH) begin
    wb = {{(`MULDIV_XLEN+2){b[`MULDIV_XLEN-1]}}, b};
  end else begin
    wb = {{(`MULDIV_XLEN+2){1'b0}}, b};
  end
  full = wa * wb;
  if (f3 == F3_MUL) begin
    return full[`MULDIV_XLEN-1:0];
  end
  return full[2*`MULDIV_XLEN-1:`MULDIV_XLEN];
endfunction

// zero divisor or most negative over minus one
function automatic logic div_special(input logic [2:0] f3,
    input logic [`MULDIV_XLEN-1:0] a, input logic [`MULDIV_XLEN-1:0] b);
  return (b == '0) ||
         (f3 != F3_DIVU && f3 != F3_REMU && a == {1'b1, {(`MULDIV_XLEN-1){1'b0}}} && b == '1);
endfunction

function automatic logic [`MULDIV_XLEN-1:0] model_div(input logic [2:0] f3,
    input logic [`MULDIV_XLEN-1:0] a, input logic [`MULDIV_XLEN-1:0] b);
  logic signed [`MULDIV_XLEN-1:0] sa;
  logic signed [`MULDIV_XLEN-1:0] sb;
  logic                           want_rem;
  want_rem = (f3 == F3_REM || f3 == F3_REMU);
  sa = a;
  sb = b;
  if (b == '0) begin
    return want_rem ? a : '1;
  end
  if (div_special(f3, a, b)) begin
    return want_rem ? '0 : a;
  end
  if (f3 == F3_DIVU || f3 == F3_REMU) begin
    return want_rem ? a % b : a / b;
  end
  // truncating division, remainder follows the dividend
  return want_rem ? sa % sb : sa / sb;
endfunction

`endif

//--- bench/muldiv_tb.sv
`timescale 1ns/1ps
`include "muldiv_cfg.svh"

module muldiv_tb;

  localparam int XLEN            = `MULDIV_XLEN;
  localparam int NUM_RANDOM      = 400;
  localparam int NUM_DIRECTED    = 12;
  // acceptance edge to the cycle that shows resp_valid_o
  localparam int LAT_MUL         = 1;
  localparam int LAT_DIV_SPECIAL = 2;
  localparam int LAT_DIV_FULL    = XLEN + 2;
  localparam int SETUP_CYCLES    = 20;
  localparam int CYCLE_LIMIT     = (NUM_RANDOM + NUM_DIRECTED) * (XLEN + 4) + SETUP_CYCLES;

  logic                     clk = 1'b0;
  logic                     reset_i;
  logic                     req_valid_i;
  logic                     req_ready_o;
  muldiv_pkg::muldiv_req_t  req_i;
  logic                     resp_valid_o;
  muldiv_pkg::muldiv_resp_t resp_o;

  logic [31:0] rng_state  = 32'd38;
  int          cycle_cnt  = 0;
  int          accept_cnt = 0;
  int          resp_cnt   = 0;
  int          req_cnt    = 0;
  int          fail_cnt   = 0;

  `include "muldiv_model.svh"

  muldiv_top u_dut (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_i        (req_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  always #20 clk = ~clk;

  // ==================================================
  // monitors and run limit
  // ==================================================

  always @(posedge clk) begin
    if (!reset_i && req_valid_i && req_ready_o) begin
      accept_cnt <= accept_cnt + 1;
    end
  end

  // response pulse spans one full cycle, so one falling edge sees it
  always @(negedge clk) begin
    if (resp_valid_o === 1'b1) begin
      resp_cnt <= resp_cnt + 1;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic report_value(input string what, input logic [31:0] exp,
      input logic [31:0] act);
    fail_cnt++;
    $display("error at %0t ns: %s expected %h got %h", $time, what, exp, act);
    $display("TEST FAIL");
    $fatal(1, "wrong value from the DUT");
  endtask

  task automatic report_fault(input string what);
    fail_cnt++;
    $display("at %0t ns: %s", $time, what);
    $display("TEST FAIL");
    $fatal(1, "DUT handshake went wrong");
  endtask

  function automatic logic [31:0] next_rand();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  // corner values in three draws of sixteen
  function automatic logic [XLEN-1:0] pick_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[31:28])
      4'd0:    return '0;
      4'd1:    return '1;
      4'd2:    return {1'b1, {(XLEN-1){1'b0}}};
      default: return next_rand();
    endcase
  endfunction

  function automatic int expected_latency(input logic [2:0] op,
      input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    if (!op[2]) begin
      return LAT_MUL;
    end
    return div_special(op, a, b) ? LAT_DIV_SPECIAL : LAT_DIV_FULL;
  endfunction

  // called at a falling edge with the DUT idle, returns at a falling edge
  task automatic run_request(input logic [2:0] op, input logic [XLEN-1:0] a,
      input logic [XLEN-1:0] b, input logic [XLEN-1:0] expected);
    int lat;
    int exp_lat;
    exp_lat = expected_latency(op, a, b);
    assert (req_ready_o === 1'b1) else report_fault("req_ready_o low while the DUT is idle");
    req_valid_i = 1'b1;
    req_i       = {op, a, b};
    req_cnt++;
    @(negedge clk);
    req_valid_i = 1'b0;
    lat = 1;
    while (resp_valid_o !== 1'b1) begin
      assert (req_ready_o === 1'b0) else report_fault("req_ready_o high during a request");
      @(negedge clk);
      lat++;
    end
    assert (req_ready_o === 1'b0) else report_fault("req_ready_o high in the response cycle");
    assert (lat == exp_lat) else report_value("response latency", 32'(exp_lat), 32'(lat));
    assert (resp_o.result === expected)
      else report_value($sformatf("op %b a %h b %h result", op, a, b), expected, resp_o.result);
    @(negedge clk);
    assert (resp_valid_o === 1'b0) else report_fault("resp_valid_o stayed high a second cycle");
    assert (req_ready_o === 1'b1) else report_fault("req_ready_o low after the response");
  endtask

  // ==================================================
  // stimulus
  // ==================================================

  initial begin
    logic [31:0]     r;
    logic [2:0]      op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    repeat (4) begin
      assert (req_ready_o === 1'b1) else report_fault("req_ready_o low after reset");
      assert (resp_valid_o === 1'b0) else report_fault("resp_valid_o high with no request");
      @(negedge clk);
    end

    // zero divisor and signed overflow
    run_request(F3_DIV,  32'h1234_5678, 32'h0000_0000, 32'hffff_ffff);
    run_request(F3_DIVU, 32'h8765_4321, 32'h0000_0000, 32'hffff_ffff);
    run_request(F3_REM,  32'h8000_0001, 32'h0000_0000, 32'h8000_0001);
    run_request(F3_REMU, 32'hdead_beef, 32'h0000_0000, 32'hdead_beef);
    run_request(F3_DIV,  32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    run_request(F3_REM,  32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
    // same operands unsigned take the full iteration
    run_request(F3_DIVU, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
    run_request(F3_REMU, 32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
    run_request(F3_DIV,  32'hffff_fff9, 32'h0000_0002, 32'hffff_fffd);
    run_request(F3_REM,  32'hffff_fff9, 32'h0000_0002, 32'hffff_ffff);
    run_request(F3_MULH, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
    run_request(F3_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);

    repeat (NUM_RANDOM) begin
      r  = next_rand();
      op = r[30:28];
      a  = pick_operand();
      b  = pick_operand();
      run_request(op, a, b, op[2] ? model_div(op, a, b) : model_mul(op, a, b));
    end

    @(posedge clk);
    assert (accept_cnt == req_cnt && resp_cnt == req_cnt)
      else report_fault($sformatf("saw %0d accepts and %0d responses for %0d requests",
                                  accept_cnt, resp_cnt, req_cnt));
    if (fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- muldiv.f
+incdir+source
+incdir+bench
source/muldiv_pkg.sv
source/iter_counter.sv
source/muldiv_ctrl.sv
source/div_datapath.sv
source/mul_unit.sv
source/muldiv_top.sv
bench/muldiv_tb.sv

//--- source/div_datapath.sv
`timescale 1ns/1ps
`include "muldiv_cfg.svh"

module div_datapath (
  input  logic                     clk,
  input  logic                     reset_i,
  input  muldiv_pkg::muldiv_req_t  req_i,
  input  muldiv_pkg::div_ctrl_t    ctrl_i,
  output logic                     special_o,
  output logic [`MULDIV_XLEN-1:0]  result_o
);

  localparam int XLEN = `MULDIV_XLEN;

  muldiv_pkg::div_view_t dv;
  logic                  a_neg;
  logic                  b_neg;
  logic                  div_zero;
  logic                  div_ovf;
  logic [XLEN-1:0]       mag_a;
  logic [XLEN-1:0]       mag_b;
  logic [XLEN-1:0]       special_res;
  logic [XLEN-1:0]       quo_q;
  logic [XLEN-1:0]       rem_q;
  logic [XLEN-1:0]       dsr_q;
  logic [XLEN-1:0]       res_q;
  logic                  q_neg_q;
  logic                  r_neg_q;
  logic                  want_rem_q;
  logic                  special_q;
  logic [XLEN:0]         shifted;
  logic [XLEN+1:0]       trial;
  logic [XLEN-1:0]       quo_fix;
  logic [XLEN-1:0]       rem_fix;

  // ==================================================
  // operand decode through the divide view
  // ==================================================

  assign dv    = req_i.op.div;
  assign a_neg = ~dv.uns & req_i.a[XLEN-1];
  assign b_neg = ~dv.uns & req_i.b[XLEN-1];
  assign mag_a = a_neg ? -req_i.a : req_i.a;
  assign mag_b = b_neg ? -req_i.b : req_i.b;

  // most negative over minus one overflows
  assign div_zero = (req_i.b == '0);
  assign div_ovf  = ~dv.uns & (req_i.a == {1'b1, {(XLEN-1){1'b0}}}) & (&req_i.b);

  always_comb begin
    if (div_zero) begin
      special_res = dv.rem ? req_i.a : '1;
    end else begin
      special_res = dv.rem ? '0 : req_i.a;
    end
  end

  // ==================================================
  // restoring step
  // ==================================================

  // next dividend bit enters the partial remainder
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign trial   = {1'b0, shifted} - {2'b00, dsr_q};

  assign quo_fix = q_neg_q ? -quo_q : quo_q;
  assign rem_fix = r_neg_q ? -rem_q : rem_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      special_q <= 1'b0;
    end else if (ctrl_i.start) begin
      special_q <= div_zero | div_ovf;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_i.start) begin
      quo_q      <= mag_a;
      rem_q      <= '0;
      dsr_q      <= mag_b;
      q_neg_q    <= a_neg ^ b_neg;
      r_neg_q    <= a_neg;
      want_rem_q <= dv.rem;
      res_q      <= special_res;
    end else if (ctrl_i.step) begin
      if (!trial[XLEN+1]) begin
        rem_q <= trial[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= shifted[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end else if (ctrl_i.finish) begin
      // remainder takes the dividend sign
      res_q <= want_rem_q ? rem_fix : quo_fix;
    end
  end

  assign special_o = special_q;
  assign result_o  = res_q;

endmodule

//--- source/iter_counter.sv
`timescale 1ns/1ps
`include "muldiv_cfg.svh"

module iter_counter (
  input  logic clk,
  input  logic reset_i,
  input  logic load_i,
  input  logic en_i,
  output logic last_o
);

  logic [`MULDIV_CNT_W-1:0] cnt_q;

  // one count per divide step, zero marks the final one
  always_ff @(posedge clk) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= `MULDIV_CNT_W'(`MULDIV_XLEN - 1);
    end else if (en_i && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last_o = (cnt_q == '0);

endmodule

//--- source/mul_unit.sv
`timescale 1ns/1ps
`include "muldiv_cfg.svh"

module mul_unit (
  input  logic                     clk,
  input  logic                     reset_i,
  input  logic                     load_i,
  input  muldiv_pkg::muldiv_req_t  req_i,
  output logic [`MULDIV_XLEN-1:0]  result_o
);

  localparam int XLEN = `MULDIV_XLEN;

  muldiv_pkg::mul_kind_e   kind;
  logic                    a_sx;
  logic                    b_sx;
  logic signed [XLEN:0]    op_a;
  logic signed [XLEN:0]    op_b;
  logic signed [2*XLEN+1:0] prod;
  logic [XLEN-1:0]         result_q;

  assign kind = req_i.op.mul.kind;

  // a is signed for MULH and MULHSU, b only for MULH
  assign a_sx = ((kind == muldiv_pkg::MUL_HSS) | (kind == muldiv_pkg::MUL_HSU)) &
                req_i.a[XLEN-1];
  assign b_sx = (kind == muldiv_pkg::MUL_HSS) & req_i.b[XLEN-1];

  assign op_a = {a_sx, req_i.a};
  assign op_b = {b_sx, req_i.b};
  assign prod = op_a * op_b;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      result_q <= '0;
    end else if (load_i) begin
      if (kind == muldiv_pkg::MUL_LO) begin
        result_q <= prod[XLEN-1:0];
      end else begin
        result_q <= prod[2*XLEN-1:XLEN];
      end
    end
  end

  assign result_o = result_q;

endmodule

//--- source/muldiv_cfg.svh
`ifndef MULDIV_CFG_SVH
`define MULDIV_CFG_SVH

// operand and result width
`define MULDIV_XLEN 32

// iteration counter, wide enough for XLEN divide steps
`define MULDIV_CNT_W 5

// funct3 bit that splits multiply from divide
`define MULDIV_OP_DIV_BIT 2

`endif

//--- source/muldiv_ctrl.sv
`timescale 1ns/1ps
`include "muldiv_cfg.svh"

module muldiv_ctrl (
  input  logic                    clk,
  input  logic                    reset_i,
  input  logic                    req_valid_i,
  input  muldiv_pkg::muldiv_req_t req_i,
  input  logic                    special_i,
  input  logic                    last_i,
  output logic                    req_ready_o,
  output muldiv_pkg::div_ctrl_t   div_ctrl_o,
  output logic                    cnt_load_o,
  output logic                    cnt_en_o,
  output logic                    resp_valid_o,
  output logic                    is_div_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MUL_DONE,
    ST_DIV_CHECK,
    ST_DIV_ITER,
    ST_DIV_FINISH,
    ST_DONE
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   accept;
  logic   req_is_div;

  assign accept     = req_valid_i & req_ready_o;
  assign req_is_div = req_i.op[`MULDIV_OP_DIV_BIT];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q  <= ST_IDLE;
      is_div_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        is_div_o <= req_is_div;
      end
    end
  end

  // ==================================================
  // next state
  // ==================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = req_is_div ? ST_DIV_CHECK : ST_MUL_DONE;
        end
      end
      ST_MUL_DONE:   state_d = ST_IDLE;
      // special cases skip the iteration
      ST_DIV_CHECK: begin
        if (special_i) begin
          state_d = ST_DONE;
        end else begin
          state_d = ST_DIV_ITER;
        end
      end
      ST_DIV_ITER: begin
        if (last_i) begin
          state_d = ST_DIV_FINISH;
        end
      end
      ST_DIV_FINISH: state_d = ST_DONE;
      ST_DONE:       state_d = ST_IDLE;
      default:       state_d = ST_IDLE;
    endcase
  end

  // divider captures operands on the acceptance edge
  assign div_ctrl_o.start  = accept & req_is_div;
  assign div_ctrl_o.step   = ((state_q == ST_DIV_CHECK) & ~special_i) |
                             (state_q == ST_DIV_ITER);
  assign div_ctrl_o.finish = (state_q == ST_DIV_FINISH);
  assign req_ready_o       = (state_q == ST_IDLE);
  assign resp_valid_o      = (state_q == ST_MUL_DONE) | (state_q == ST_DONE);
  assign cnt_load_o        = div_ctrl_o.start;
  assign cnt_en_o          = div_ctrl_o.step;

endmodule

//--- source/muldiv_pkg.sv
`include "muldiv_cfg.svh"

package muldiv_pkg;

  // ==================================================
  // opcode views, values match RV32M funct3
  // ==================================================

  typedef enum logic [1:0] {
    MUL_LO  = 2'b00,
    MUL_HSS = 2'b01,
    MUL_HSU = 2'b10,
    MUL_HUU = 2'b11
  } mul_kind_e;

  typedef struct packed {
    logic      group;
    mul_kind_e kind;
  } mul_view_t;

  // rem selects remainder, uns selects unsigned
  typedef struct packed {
    logic group;
    logic rem;
    logic uns;
  } div_view_t;

  typedef union packed {
    mul_view_t mul;
    div_view_t div;
  } m_op_u;

  // ==================================================
  // request, response and divider steering
  // ==================================================

  typedef struct packed {
    m_op_u                   op;
    logic [`MULDIV_XLEN-1:0] a;
    logic [`MULDIV_XLEN-1:0] b;
  } muldiv_req_t;

  typedef struct packed {
    logic [`MULDIV_XLEN-1:0] result;
  } muldiv_resp_t;

  typedef struct packed {
    logic start;
    logic step;
    logic finish;
  } div_ctrl_t;

endpackage

//--- source/muldiv_top.sv
`timescale 1ns/1ps
`include "muldiv_cfg.svh"

module muldiv_top (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  muldiv_pkg::muldiv_req_t   req_i,
  output logic                      resp_valid_o,
  output muldiv_pkg::muldiv_resp_t  resp_o
);

  logic                    accept;
  logic                    special;
  logic                    last;
  logic                    cnt_load;
  logic                    cnt_en;
  logic                    is_div;
  muldiv_pkg::div_ctrl_t   div_ctrl;
  logic [`MULDIV_XLEN-1:0] div_result;
  logic [`MULDIV_XLEN-1:0] mul_result;

  // multiplier samples operands on the acceptance edge
  assign accept = req_valid_i & req_ready_o;

  muldiv_ctrl u_ctrl (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .special_i    (special),
    .last_i       (last),
    .req_ready_o  (req_ready_o),
    .div_ctrl_o   (div_ctrl),
    .cnt_load_o   (cnt_load),
    .cnt_en_o     (cnt_en),
    .resp_valid_o (resp_valid_o),
    .is_div_o     (is_div)
  );

  iter_counter u_counter (
    .clk     (clk),
    .reset_i (reset_i),
    .load_i  (cnt_load),
    .en_i    (cnt_en),
    .last_o  (last)
  );

  div_datapath u_div (
    .clk       (clk),
    .reset_i   (reset_i),
    .req_i     (req_i),
    .ctrl_i    (div_ctrl),
    .special_o (special),
    .result_o  (div_result)
  );

  mul_unit u_mul (
    .clk      (clk),
    .reset_i  (reset_i),
    .load_i   (accept),
    .req_i    (req_i),
    .result_o (mul_result)
  );

  // group bit of the accepted request picks the result
  assign resp_o.result = is_div ? div_result : mul_result;

endmodule
